// File: hw/gemm_accel_top.sv
`timescale 1ns/100ps

module gemm_accel_top import gemm_pkg::*; #(
  parameter int unsigned MatDim   = gemm_pkg::MatDim,
  parameter int unsigned NumPorts = gemm_pkg::NumPorts
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  host_req_t               host_req_i,
  output host_rsp_t               host_rsp_o,
  output mem_req_t [NumPorts-1:0] mem_req_o,
  input  mem_rsp_t [NumPorts-1:0] mem_rsp_i
);

  logic                    start;
  logic [31:0]             base_a;
  logic [31:0]             base_b;
  logic [31:0]             base_c;
  mem_req_t [NumPorts-1:0] fetch_req;
  logic                    fetch_done;
  mat_t                    a_mat;
  mat_t                    b_mat;
  logic                    mac_done;
  res_t                    res;
  logic                    wb_done;

  gemm_csr gemm_csr_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .host_req_i (host_req_i),
    .wb_done_i  (wb_done),
    .host_rsp_o (host_rsp_o),
    .start_o    (start),
    .base_a_o   (base_a),
    .base_b_o   (base_b),
    .base_c_o   (base_c)
  );

  gemm_fetch #(
    .MatDim   (MatDim),
    .NumPorts (NumPorts)
  ) gemm_fetch_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .base_a_i     (base_a),
    .base_b_i     (base_b),
    .mem_rsp_i    (mem_rsp_i),
    .fetch_req_o  (fetch_req),
    .fetch_done_o (fetch_done),
    .a_o          (a_mat),
    .b_o          (b_mat)
  );

  gemm_mac_array #(
    .MatDim (MatDim)
  ) gemm_mac_array_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (fetch_done),
    .a_i        (a_mat),
    .b_i        (b_mat),
    .mac_done_o (mac_done),
    .res_o      (res)
  );

  gemm_writeback #(
    .MatDim   (MatDim),
    .NumPorts (NumPorts)
  ) gemm_writeback_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (mac_done),
    .base_c_i    (base_c),
    .res_i       (res),
    .fetch_req_i (fetch_req),
    .mem_req_o   (mem_req_o),
    .wb_done_o   (wb_done)
  );

endmodule

// File: hw/gemm_csr.sv
`timescale 1ns/100ps

module gemm_csr import gemm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  host_req_t   host_req_i,
  input  logic        wb_done_i,
  output host_rsp_t   host_rsp_o,
  output logic        start_o,
  output logic [31:0] base_a_o,
  output logic [31:0] base_b_o,
  output logic [31:0] base_c_o
);

  logic [11:0] csr_idx;
  logic        rd_req;
  logic        wr_req;
  logic        start_req;
  logic [31:0] rdata;

  logic [31:0] base_a_q;
  logic [31:0] base_b_q;
  logic [31:0] base_c_q;
  logic        start_q;
  logic        busy_q;
  logic        done_q;

  logic        rsp_valid_q;
  logic [31:0] rsp_data_q;
  logic [4:0]  rsp_id_q;

  // register index inside the window
  assign csr_idx = host_req_i.addr - CsrOffset;

  // op decode
  always_comb begin
    rd_req = 1'b0;
    wr_req = 1'b0;
    if (host_req_i.valid) begin
      case (host_req_i.op)
        CSRRS, CSRRC, CSRRSI, CSRRCI: rd_req = 1'b1;
        CSRRW, CSRRWI: wr_req = 1'b1;
        default: begin
        end
      endcase
    end
  end

  // starts while busy are dropped
  assign start_req = wr_req && (csr_idx == CsrStart) && !busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_a_q <= '0;
      base_b_q <= '0;
      base_c_q <= '0;
    end else if (wr_req) begin
      case (csr_idx)
        CsrBaseA: base_a_q <= host_req_i.data;
        CsrBaseB: base_b_q <= host_req_i.data;
        CsrBaseC: base_c_q <= host_req_i.data;
        default: begin
        end
      endcase
    end
  end

  // run state, done stays set until the next start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= start_req;
      if (start_req) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (wb_done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (csr_idx)
      CsrBaseA: rdata = base_a_q;
      CsrBaseB: rdata = base_b_q;
      CsrBaseC: rdata = base_c_q;
      CsrStatus: rdata = {30'b0, done_q, busy_q};
      default: rdata = '0;
    endcase
  end

  // read answer one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rsp_data_q <= rdata;
      rsp_id_q   <= host_req_i.id;
    end
  end

  assign host_rsp_o.valid = rsp_valid_q;
  assign host_rsp_o.data  = rsp_data_q;
  assign host_rsp_o.id    = rsp_id_q;

  assign start_o  = start_q;
  assign base_a_o = base_a_q;
  assign base_b_o = base_b_q;
  assign base_c_o = base_c_q;

endmodule

// File: hw/gemm_fetch.sv
`timescale 1ns/100ps

module gemm_fetch import gemm_pkg::*; #(
  parameter int unsigned MatDim   = gemm_pkg::MatDim,
  parameter int unsigned NumPorts = gemm_pkg::NumPorts
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic [31:0]             base_a_i,
  input  logic [31:0]             base_b_i,
  input  mem_rsp_t [NumPorts-1:0] mem_rsp_i,
  output mem_req_t [NumPorts-1:0] fetch_req_o,
  output logic                    fetch_done_o,
  output mat_t                    a_o,
  output mat_t                    b_o
);

  logic                                issue_q;
  logic                                waiting_q;
  logic                                done_q;
  logic [NumPorts-1:0]                 pending_q;
  logic [NumPorts-1:0]                 rsp_valid;
  logic [NumPorts-1:0]                 pending_next;
  logic [NumPorts-1:0][DataWidth-1:0] data_q;

  // one read per port, A rows low, B rows high
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      fetch_req_o[i].valid = issue_q;
      fetch_req_o[i].write = 1'b0;
      fetch_req_o[i].data  = '0;
      if (i < MatDim) begin
        fetch_req_o[i].addr = base_a_i + 32'(i * WordBytes);
      end else begin
        fetch_req_o[i].addr = base_b_i + 32'((i - MatDim) * WordBytes);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      rsp_valid[i] = mem_rsp_i[i].valid;
    end
  end

  assign pending_next = pending_q & ~rsp_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q   <= 1'b0;
      waiting_q <= 1'b0;
      done_q    <= 1'b0;
      pending_q <= '0;
    end else begin
      issue_q <= start_i;
      done_q  <= 1'b0;
      if (issue_q) begin
        pending_q <= '1;
        waiting_q <= 1'b1;
      end else begin
        pending_q <= pending_next;
        // last outstanding port answered
        if (waiting_q && (pending_next == '0)) begin
          waiting_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  // ports answer in any order
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumPorts; i++) begin
      if (rsp_valid[i] && pending_q[i]) begin
        data_q[i] <= mem_rsp_i[i].data;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < MatDim; r++) begin
      a_o[r] = data_q[r];
      b_o[r] = data_q[r + MatDim];
    end
  end

  assign fetch_done_o = done_q;

endmodule

// File: hw/gemm_mac_array.sv
`timescale 1ns/100ps

module gemm_mac_array import gemm_pkg::*; #(
  parameter int unsigned MatDim = gemm_pkg::MatDim
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  mat_t a_i,
  input  mat_t b_i,
  output logic mac_done_o,
  output res_t res_o
);

  localparam int unsigned RowW = (MatDim > 1) ? $clog2(MatDim) : 1;

  logic                             active_q;
  logic                             done_q;
  logic [RowW-1:0]                  row_q;
  logic [DataWidth-1:0]             a_row;
  logic [MatDim-1:0][AccWidth-1:0] row_sum;
  res_t                             res_q;

  assign a_row = a_i[row_q];

  // one dot product per column of B
  always_comb begin
    logic signed [ElemWidth-1:0]   a_el;
    logic signed [ElemWidth-1:0]   b_el;
    logic signed [2*ElemWidth-1:0] prod;
    logic signed [AccWidth-1:0]    acc;
    for (int j = 0; j < MatDim; j++) begin
      acc = '0;
      for (int k = 0; k < MatDim; k++) begin
        a_el = a_row[k*ElemWidth +: ElemWidth];
        b_el = b_i[k][j*ElemWidth +: ElemWidth];
        prod = a_el * b_el;
        // sign extend before summing
        acc = acc + AccWidth'(prod);
      end
      row_sum[j] = acc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      row_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        active_q <= 1'b1;
        row_q    <= '0;
      end else if (active_q) begin
        if (row_q == RowW'(MatDim - 1)) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active_q) begin
      for (int j = 0; j < MatDim; j++) begin
        res_q[int'(row_q) * MatDim + j] <= row_sum[j];
      end
    end
  end

  assign res_o      = res_q;
  assign mac_done_o = done_q;

endmodule

// File: hw/gemm_pkg.sv
package gemm_pkg;

  // matrix and datapath sizes
  localparam int unsigned MatDim = 4;
  localparam int unsigned ElemWidth = 8;
  localparam int unsigned AccWidth = 32;
  localparam int unsigned DataWidth = MatDim * ElemWidth;
  // ports 0..MatDim-1 carry A rows, the rest carry B rows
  localparam int unsigned NumPorts = 2 * MatDim;
  localparam int unsigned WordBytes = 4;

  // csr window
  localparam logic [11:0] CsrOffset = 12'h3c0;
  localparam logic [11:0] CsrBaseA = 12'd0;
  localparam logic [11:0] CsrBaseB = 12'd1;
  localparam logic [11:0] CsrBaseC = 12'd2;
  localparam logic [11:0] CsrStart = 12'd3;
  localparam logic [11:0] CsrStatus = 12'd4;

  // set and clear forms read, the two write forms write
  typedef enum logic [2:0] {
    CSRRW  = 3'd0,
    CSRRS  = 3'd1,
    CSRRC  = 3'd2,
    CSRRWI = 3'd3,
    CSRRSI = 3'd4,
    CSRRCI = 3'd5
  } csr_op_e;

  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [4:0]  id;
  } host_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [4:0]  id;
  } host_rsp_t;

  // one per memory port
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [31:0]          addr;
    logic [DataWidth-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                 valid;
    logic [DataWidth-1:0] data;
  } mem_rsp_t;

  // one row per word, element k at bits k*ElemWidth
  typedef logic [MatDim-1:0][DataWidth-1:0] mat_t;
  // row-major result elements
  typedef logic [MatDim*MatDim-1:0][AccWidth-1:0] res_t;

endpackage

// File: hw/gemm_writeback.sv
`timescale 1ns/100ps

module gemm_writeback import gemm_pkg::*; #(
  parameter int unsigned MatDim   = gemm_pkg::MatDim,
  parameter int unsigned NumPorts = gemm_pkg::NumPorts
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic [31:0]             base_c_i,
  input  res_t                    res_i,
  input  mem_req_t [NumPorts-1:0] fetch_req_i,
  output mem_req_t [NumPorts-1:0] mem_req_o,
  output logic                    wb_done_o
);

  // bursts needed to cover the whole result
  localparam int unsigned NumPhases = (MatDim * MatDim) / NumPorts;
  localparam int unsigned PhaseW = (NumPhases > 1) ? $clog2(NumPhases) : 1;

  logic              active_q;
  logic [PhaseW-1:0] phase_q;
  logic              last_phase;

  assign last_phase = (phase_q == PhaseW'(NumPhases - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      phase_q  <= '0;
    end else begin
      if (start_i) begin
        active_q <= 1'b1;
        phase_q  <= '0;
      end else if (active_q) begin
        if (last_phase) begin
          active_q <= 1'b0;
        end else begin
          phase_q <= phase_q + 1'b1;
        end
      end
    end
  end

  // write burst owns every port, otherwise pass the fetch reads through
  always_comb begin
    int unsigned idx;
    for (int j = 0; j < NumPorts; j++) begin
      idx = int'(phase_q) * NumPorts + j;
      if (active_q) begin
        mem_req_o[j].valid = 1'b1;
        mem_req_o[j].write = 1'b1;
        mem_req_o[j].addr  = base_c_i + 32'(idx * WordBytes);
        mem_req_o[j].data  = DataWidth'(res_i[idx]);
      end else begin
        mem_req_o[j] = fetch_req_i[j];
      end
    end
  end

  assign wb_done_o = active_q && last_phase;

endmodule

// File: project.f
hw/gemm_pkg.sv
hw/gemm_csr.sv
hw/gemm_fetch.sv
hw/gemm_mac_array.sv
hw/gemm_writeback.sv
hw/gemm_accel_top.sv
testbench/gemm_checker.sv
testbench/gemm_tb.sv

// File: testbench/gemm_checker.sv
`timescale 1ns/100ps

module gemm_checker import gemm_pkg::*; #(
  parameter int unsigned NumPorts = gemm_pkg::NumPorts
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input host_req_t               host_req_i,
  input host_rsp_t               host_rsp_i,
  input mem_req_t [NumPorts-1:0] mem_req_i
);

  int unsigned fail_count;

  logic rd_req;
  logic any_valid;
  logic any_wr;
  logic any_rd;
  logic all_wr;

  initial fail_count = 0;

  // set and clear forms are the read class
  assign rd_req = host_req_i.valid &&
                  (host_req_i.op inside {CSRRS, CSRRC, CSRRSI, CSRRCI});

  always_comb begin
    any_valid = 1'b0;
    any_wr    = 1'b0;
    any_rd    = 1'b0;
    all_wr    = 1'b1;
    for (int i = 0; i < NumPorts; i++) begin
      any_valid = any_valid | mem_req_i[i].valid;
      any_wr    = any_wr | (mem_req_i[i].valid & mem_req_i[i].write);
      any_rd    = any_rd | (mem_req_i[i].valid & ~mem_req_i[i].write);
      all_wr    = all_wr & mem_req_i[i].valid & mem_req_i[i].write;
    end
  end

  // answer in the next cycle, same id
  rsp_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req |=> host_rsp_i.valid && (host_rsp_i.id == $past(host_req_i.id)))
  else begin
    fail_count++;
    $error("read response missing, late or with a wrong id");
  end

  rsp_only_for_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp_i.valid |-> $past(rd_req))
  else begin
    fail_count++;
    $error("host response without a read request");
  end

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !any_valid && !host_rsp_i.valid)
  else begin
    fail_count++;
    $error("valid strobe while in reset");
  end

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !any_valid && !host_rsp_i.valid)
  else begin
    fail_count++;
    $error("valid strobe in the first cycle after reset");
  end

  // a write burst uses every port
  wr_all_ports: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_wr |-> all_wr)
  else begin
    fail_count++;
    $error("write burst does not cover all ports");
  end

  no_mixed_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(any_wr && any_rd))
  else begin
    fail_count++;
    $error("read and write requests in the same cycle");
  end

  two_beat_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(all_wr) |=> all_wr ##1 !all_wr)
  else begin
    fail_count++;
    $error("write-back is not exactly two consecutive bursts");
  end

endmodule

bind gemm_accel_top gemm_checker #(
  .NumPorts (NumPorts)
) gemm_checker_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .host_req_i (host_req_i),
  .host_rsp_i (host_rsp_o),
  .mem_req_i  (mem_req_o)
);

// File: testbench/gemm_tb.sv
`timescale 1ns/100ps

module gemm_tb import gemm_pkg::*; ();

  localparam int RspTimeout = 8;
  localparam int RunPolls   = 60;
  localparam int NumRuns    = 3;

  logic                    clk_i;
  logic                    rst_ni;
  host_req_t               host_req_i;
  host_rsp_t               host_rsp_o;
  mem_req_t [NumPorts-1:0] mem_req_o;
  mem_rsp_t [NumPorts-1:0] mem_rsp_i;

  // sparse memory, one word per address
  logic [31:0] mem [logic [31:0]];
  logic [31:0] base_a;
  logic [31:0] base_b;
  logic [31:0] base_c;
  int          mats [2][MatDim][MatDim];
  int          lat_cnt [NumPorts];
  logic [31:0] lat_data [NumPorts];
  int unsigned error_count;
  int unsigned read_bursts;
  int unsigned write_count;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned test_base;
  logic [4:0]  next_id;
  csr_op_e     read_ops [4] = '{CSRRS, CSRRC, CSRRSI, CSRRCI};
  logic [11:0] base_regs [3] = '{CsrBaseA, CsrBaseB, CsrBaseC};

  gemm_accel_top gemm_accel_top_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .mem_req_o  (mem_req_o),
    .mem_rsp_i  (mem_rsp_i)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  function automatic int unsigned total_errors();
    return error_count + gemm_accel_top_i.gemm_checker_i.fail_count;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    error_count++;
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic begin_test();
    test_base = total_errors();
  endtask

  task automatic end_test(input string name);
    int unsigned errs;
    errs = total_errors() - test_base;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // memory model, reads answered after 1 to 5 cycles per port
  always begin
    logic [31:0] exp_addr;
    logic        any_rd;
    @(posedge clk_i);
    #10;
    any_rd = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      mem_rsp_i[i] = '0;
      if (lat_cnt[i] > 0) begin
        lat_cnt[i]--;
        if (lat_cnt[i] == 0) begin
          mem_rsp_i[i].valid = 1'b1;
          mem_rsp_i[i].data  = lat_data[i];
        end
      end
      if (mem_req_o[i].valid && mem_req_o[i].write) begin
        mem[mem_req_o[i].addr] = mem_req_o[i].data;
        write_count++;
      end else if (mem_req_o[i].valid) begin
        any_rd = 1'b1;
        if (i < MatDim) begin
          exp_addr = base_a + 32'(i * WordBytes);
        end else begin
          exp_addr = base_b + 32'((i - MatDim) * WordBytes);
        end
        assert (mem_req_o[i].addr == exp_addr)
        else report_mismatch($sformatf("mem_req_o[%0d].addr", i), exp_addr,
                             mem_req_o[i].addr);
        if (mem.exists(mem_req_o[i].addr)) begin
          lat_data[i] = mem[mem_req_o[i].addr];
        end else begin
          error_count++;
          lat_data[i] = '0;
          $display("port %0d read address %h outside the loaded operand rows",
                   i, mem_req_o[i].addr);
        end
        lat_cnt[i] = 1 + int'($urandom % 5);
      end
    end
    if (any_rd) begin
      read_bursts++;
    end
  end

  task automatic csr_write(input logic [11:0] idx, input logic [31:0] data);
    host_req_i.valid = 1'b1;
    // alternate the two write forms
    if (next_id[0]) begin
      host_req_i.op = CSRRWI;
    end else begin
      host_req_i.op = CSRRW;
    end
    host_req_i.addr  = CsrOffset + idx;
    host_req_i.data  = data;
    host_req_i.id    = next_id;
    next_id++;
    step();
    host_req_i = '0;
  endtask

  task automatic csr_read(input logic [11:0] idx, output logic [31:0] data);
    logic [4:0] id;
    int         n;
    id = next_id;
    host_req_i.valid = 1'b1;
    host_req_i.op    = read_ops[id[1:0]];
    host_req_i.addr  = CsrOffset + idx;
    host_req_i.data  = '0;
    host_req_i.id    = id;
    next_id++;
    step();
    host_req_i = '0;
    n = 0;
    while (!host_rsp_o.valid) begin
      if (n == RspTimeout) begin
        stop_on_timeout("no response to a CSR read");
      end
      step();
      n++;
    end
    assert (host_rsp_o.id == id)
    else report_mismatch("host_rsp_o.id", 32'(id), 32'(host_rsp_o.id));
    data = host_rsp_o.data;
  endtask

  task automatic check_csr_access();
    logic [31:0] vals [3];
    logic [31:0] got;
    begin_test();
    for (int i = 0; i < 3; i++) begin
      vals[i] = $urandom;
      csr_write(base_regs[i], vals[i]);
    end
    for (int i = 0; i < 3; i++) begin
      csr_read(base_regs[i], got);
      assert (got == vals[i])
      else report_mismatch("host_rsp_o.data", vals[i], got);
    end
    end_test("csr access");
  endtask

  task automatic run_product(input int run);
    logic signed [ElemWidth-1:0] el;
    logic [31:0] word;
    logic [31:0] status;
    logic [31:0] exp;
    logic [31:0] addr;
    int          acc;
    int          polls;
    begin_test();
    mem.delete();
    read_bursts = 0;
    write_count = 0;
    // A, B and C regions kept apart
    base_a = $urandom & 32'h0fff_f000;
    base_b = base_a + 32'h100;
    base_c = base_a + 32'h200;
    for (int m = 0; m < 2; m++) begin
      for (int r = 0; r < MatDim; r++) begin
        word = '0;
        for (int k = 0; k < MatDim; k++) begin
          el = ElemWidth'($urandom);
          mats[m][r][k] = el;
          word[k*ElemWidth +: ElemWidth] = el;
        end
        mem[(m == 0 ? base_a : base_b) + 32'(r * WordBytes)] = word;
      end
    end
    csr_write(CsrBaseA, base_a);
    csr_write(CsrBaseB, base_b);
    csr_write(CsrBaseC, base_c);
    csr_write(CsrStart, 32'h1);
    csr_read(CsrStatus, status);
    assert (status == 32'h1) else report_mismatch("status", 32'h1, status);
    // still busy, so this start is dropped
    csr_write(CsrStart, 32'h1);
    polls = 0;
    status = '0;
    while (!status[1]) begin
      if (polls == RunPolls) begin
        stop_on_timeout("run never reported done");
      end
      csr_read(CsrStatus, status);
      polls++;
    end
    assert (status == 32'h2) else report_mismatch("status", 32'h2, status);
    assert (read_bursts == 1) else report_mismatch("read bursts", 1, read_bursts);
    assert (write_count == MatDim * MatDim)
    else report_mismatch("write count", MatDim * MatDim, write_count);
    for (int r = 0; r < MatDim; r++) begin
      for (int c = 0; c < MatDim; c++) begin
        acc = 0;
        for (int k = 0; k < MatDim; k++) begin
          acc += mats[0][r][k] * mats[1][k][c];
        end
        exp = 32'(acc);
        addr = base_c + 32'((r * MatDim + c) * WordBytes);
        if (!mem.exists(addr)) begin
          error_count++;
          $display("result element %0d,%0d was never written to %h", r, c, addr);
        end else begin
          assert (mem[addr] == exp)
          else report_mismatch($sformatf("C[%0d][%0d]", r, c), exp, mem[addr]);
        end
      end
    end
    end_test($sformatf("product run %0d", run));
  endtask

  initial begin
    void'($urandom(72461));
    host_req_i = '0;
    mem_rsp_i  = '0;
    rst_ni     = 1'b1;
    next_id    = '0;
    base_a     = '0;
    base_b     = '0;
    base_c     = '0;
    // reset asserted before the first rising edge
    #10;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    step();
    check_csr_access();
    for (int run = 0; run < NumRuns; run++) begin
      run_product(run);
    end
    step();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
